/* rtl/afu_pkg.sv */
// Shared types and widths of the accelerator compute unit
// State encodings, response opcodes and datapath widths

package afu_pkg;

	//////////////////////////////
	// Datapath widths
	//////////////////////////////

	// Job length and response count
	parameter int LENGTH_WIDTH = 16;
	// Data of one memory response
	parameter int DATA_WIDTH   = 32;
	// Each statistics counter
	parameter int STAT_WIDTH   = 32;
	// Return word with bit 0 as the MSB
	parameter int RETURN_WIDTH = 64;
	// Lower part of the return word holds the data sum
	parameter int SUM_WIDTH    = RETURN_WIDTH - LENGTH_WIDTH;

	//////////////////////////////
	// Encodings
	//////////////////////////////

	// Done state machine
	typedef enum logic [2:0] {
		DONE_RESET         = 3'd0,
		DONE_IDLE          = 3'd1,
		DONE_RESET_REQ     = 3'd2,
		DONE_RESET_PENDING = 3'd3,
		DONE_MMIO_REQ      = 3'd4
	} done_state;

	// Job engine
	typedef enum logic [1:0] {
		ENGINE_IDLE = 2'd0,
		ENGINE_RUN  = 2'd1,
		ENGINE_DONE = 2'd2
	} engine_state;

	// Kind of a memory response
	typedef enum logic [1:0] {
		RESP_READ  = 2'd0,
		RESP_WRITE = 2'd1,
		RESP_ERROR = 2'd2
	} resp_kind;

endpackage

/* rtl/response_stats_if.sv */
`timescale 1ns/1ps
// Response statistics bundle
// Read, write and error counts plus busy cycles of one job

interface response_stats_if import afu_pkg::*; ();

	// Responses by kind
	logic [STAT_WIDTH-1:0] reads;
	logic [STAT_WIDTH-1:0] writes;
	logic [STAT_WIDTH-1:0] errors;
	// Cycles with a job running
	logic [STAT_WIDTH-1:0] busy_cycles;

	// Side that owns the counters
	modport producer (
		output reads,
		output writes,
		output errors,
		output busy_cycles
	);

	// Side that samples them
	modport consumer (
		input reads,
		input writes,
		input errors,
		input busy_cycles
	);

endinterface

/* rtl/job_engine.sv */
`timescale 1ns/1ps
// Job engine of the compute unit
// Counts the responses of one job, sums their data and flags completion

module job_engine import afu_pkg::*; (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    soft_rstn,
	input  logic                    job_start,
	input  logic [LENGTH_WIDTH-1:0] job_length,
	input  logic                    resp_valid,
	input  afu_pkg::resp_kind       resp_kind,
	input  logic [DATA_WIDTH-1:0]   resp_data,
	output logic                    cu_done,
	output logic [0:RETURN_WIDTH-1] cu_return,
	output logic                    job_running,
	output logic                    job_busy
);

	engine_state             state;
	logic [LENGTH_WIDTH-1:0] length_q;
	logic [LENGTH_WIDTH-1:0] resp_count;
	logic [SUM_WIDTH-1:0]    data_sum;
	logic [SUM_WIDTH-1:0]    resp_addend;
	logic                    last_resp;

	// Error responses carry no data
	assign resp_addend = (resp_kind == RESP_ERROR) ? '0 : SUM_WIDTH'(resp_data);

	// Response that completes the job
	assign last_resp = resp_valid && ((resp_count + 1'b1) == length_q);

	//////////////////////////////
	// Engine FSM and datapath
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state      <= ENGINE_IDLE;
			length_q   <= '0;
			resp_count <= '0;
			data_sum   <= '0;
		end else if (!soft_rstn) begin
			// Soft reset from the done path
			state      <= ENGINE_IDLE;
			length_q   <= '0;
			resp_count <= '0;
			data_sum   <= '0;
		end else begin
			case (state)
				ENGINE_IDLE : begin
					if (job_start) begin
						length_q   <= job_length;
						resp_count <= '0;
						data_sum   <= '0;
						// Empty job finishes at once
						state      <= (job_length == '0) ? ENGINE_DONE : ENGINE_RUN;
					end
				end
				ENGINE_RUN : begin
					if (resp_valid) begin
						resp_count <= resp_count + 1'b1;
						data_sum   <= data_sum + resp_addend;
						if (last_resp)
							state <= ENGINE_DONE;
					end
				end
				ENGINE_DONE : begin
					// Result held until soft reset
					state <= ENGINE_DONE;
				end
				default : begin
					state <= ENGINE_IDLE;
				end
			endcase
		end
	end

	// Count in the upper bits, sum in the lower bits
	assign cu_return   = {resp_count, data_sum};
	assign cu_done     = (state == ENGINE_DONE);
	assign job_running = (state == ENGINE_RUN);
	assign job_busy    = (state != ENGINE_IDLE);

	// Never more responses than asked for
	a_count_in_length : assert property (
		@(posedge clock) disable iff (!rstn)
		resp_count <= length_q
	);

endmodule

/* rtl/response_counter.sv */
`timescale 1ns/1ps
// Response statistics of the running job
// Counts responses per kind and cycles spent busy

module response_counter import afu_pkg::*; (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      soft_rstn,
	input  logic                      job_running,
	input  logic                      resp_valid,
	input  afu_pkg::resp_kind         resp_kind,
	response_stats_if.producer        stats
);

	logic [STAT_WIDTH-1:0] reads_q;
	logic [STAT_WIDTH-1:0] writes_q;
	logic [STAT_WIDTH-1:0] errors_q;
	logic [STAT_WIDTH-1:0] busy_q;
	logic                  count_en;
	logic [STAT_WIDTH+1:0] resp_total;

	// Strobes outside a job are dropped
	assign count_en = job_running && resp_valid;

	//////////////////////////////
	// Counters
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			reads_q  <= '0;
			writes_q <= '0;
			errors_q <= '0;
			busy_q   <= '0;
		end else if (!soft_rstn) begin
			reads_q  <= '0;
			writes_q <= '0;
			errors_q <= '0;
			busy_q   <= '0;
		end else begin
			if (job_running)
				busy_q <= busy_q + 1'b1;
			if (count_en) begin
				case (resp_kind)
					RESP_WRITE : writes_q <= writes_q + 1'b1;
					RESP_ERROR : errors_q <= errors_q + 1'b1;
					// Reads and anything unknown
					default    : reads_q  <= reads_q + 1'b1;
				endcase
			end
		end
	end

	assign stats.reads       = reads_q;
	assign stats.writes      = writes_q;
	assign stats.errors      = errors_q;
	assign stats.busy_cycles = busy_q;

	// All responses seen so far
	assign resp_total = {2'b00, reads_q} + {2'b00, writes_q} + {2'b00, errors_q};

	// Total only grows while no soft reset is applied
	a_total_monotonic : assert property (
		@(posedge clock) disable iff (!rstn)
		soft_rstn |=> resp_total >= $past(resp_total)
	);

endmodule

/* rtl/soft_reset_ctrl.sv */
`timescale 1ns/1ps
// Soft reset generator
// Stretches the reset request into a low pulse of fixed length

module soft_reset_ctrl #(
	parameter int SOFT_RESET_CYCLES = 4
) (
	input  logic clock,
	input  logic rstn,
	input  logic reset_done,
	output logic soft_rstn
);

	localparam int CNT_WIDTH = $clog2(SOFT_RESET_CYCLES + 1);

	logic                 reset_done_q;
	logic                 reset_req;
	logic [CNT_WIDTH-1:0] pulse_cnt;

	// Request is the falling edge of reset_done
	assign reset_req = reset_done_q && !reset_done;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			reset_done_q <= 1'b1;
			pulse_cnt    <= '0;
		end else begin
			reset_done_q <= reset_done;
			if (reset_req)
				pulse_cnt <= CNT_WIDTH'(SOFT_RESET_CYCLES);
			else if (pulse_cnt != '0)
				pulse_cnt <= pulse_cnt - 1'b1;
		end
	end

	// Low while the pulse is counting down
	assign soft_rstn = (pulse_cnt == '0);

	// Pulse never outlasts its length
	a_pulse_length : assert property (
		@(posedge clock) disable iff (!rstn)
		!soft_rstn [*SOFT_RESET_CYCLES] |=> soft_rstn
	);

endmodule

/* rtl/done_control.sv */
`timescale 1ns/1ps
// Completion control of the compute unit
// Latches results, soft resets the engine and holds the MMIO report until ack

module done_control import afu_pkg::*; (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    soft_rstn,
	input  logic                    enabled_in,
	input  logic                    cu_done,
	input  logic [0:RETURN_WIDTH-1] cu_return,
	response_stats_if.consumer      live_stats,
	input  logic                    done_ack,
	output logic                    reset_done,
	output logic                    return_valid,
	output logic [0:RETURN_WIDTH-1] return_done,
	response_stats_if.producer      report_stats
);

	done_state               state;
	done_state               next_state;
	logic                    enabled;
	logic                    soft_sync_1;
	logic                    soft_sync_2;
	logic                    soft_rise;
	logic [0:RETURN_WIDTH-1] return_latched;
	logic [STAT_WIDTH-1:0]   lat_reads;
	logic [STAT_WIDTH-1:0]   lat_writes;
	logic [STAT_WIDTH-1:0]   lat_errors;
	logic [STAT_WIDTH-1:0]   lat_busy;

	//////////////////////////////
	// Soft reset edge
	//////////////////////////////

	// Two stage sync then rising edge
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			soft_sync_1 <= 1'b1;
			soft_sync_2 <= 1'b1;
			soft_rise   <= 1'b0;
		end else begin
			soft_sync_1 <= soft_rstn;
			soft_sync_2 <= soft_sync_1;
			soft_rise   <= soft_sync_1 && !soft_sync_2;
		end
	end

	//////////////////////////////
	// Enable
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			enabled <= 1'b0;
		else
			enabled <= enabled_in;
	end

	//////////////////////////////
	// Done FSM
	//////////////////////////////

	// Frozen while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			state <= DONE_RESET;
		else if (enabled)
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			DONE_RESET : begin
				next_state = DONE_IDLE;
			end
			DONE_IDLE : begin
				if (cu_done)
					next_state = DONE_RESET_REQ;
			end
			DONE_RESET_REQ : begin
				next_state = DONE_RESET_PENDING;
			end
			DONE_RESET_PENDING : begin
				// Engine cleared so the report can go out
				if (soft_rise)
					next_state = DONE_MMIO_REQ;
			end
			DONE_MMIO_REQ : begin
				if (done_ack)
					next_state = DONE_IDLE;
			end
			default : begin
				next_state = DONE_RESET;
			end
		endcase
	end

	//////////////////////////////
	// Result capture
	//////////////////////////////

	// Tracks live values until the FSM leaves idle
	always_ff @(posedge clock) begin
		if (state == DONE_IDLE) begin
			return_latched <= cu_return;
			lat_reads      <= live_stats.reads;
			lat_writes     <= live_stats.writes;
			lat_errors     <= live_stats.errors;
			lat_busy       <= live_stats.busy_cycles;
		end
	end

	// One low cycle per request
	assign reset_done = !(enabled && (state == DONE_RESET_REQ));

	// MMIO report is zero outside the report state
	assign return_valid             = (state == DONE_MMIO_REQ);
	assign return_done              = return_valid ? return_latched : '0;
	assign report_stats.reads       = return_valid ? lat_reads : '0;
	assign report_stats.writes      = return_valid ? lat_writes : '0;
	assign report_stats.errors      = return_valid ? lat_errors : '0;
	assign report_stats.busy_cycles = return_valid ? lat_busy : '0;

	// Report shown only with the soft reset released
	a_valid_after_reset : assert property (
		@(posedge clock) disable iff (!rstn)
		return_valid |-> soft_rstn
	);

	// Report held steady until the host acks
	a_report_stable : assert property (
		@(posedge clock) disable iff (!rstn)
		(return_valid && !done_ack) |=> (return_valid && $stable(return_done))
	);

endmodule

/* rtl/afu_core.sv */
`timescale 1ns/1ps
// Accelerator compute unit top level
// Job engine, response statistics, soft reset and completion report

module afu_core import afu_pkg::*; #(
	parameter int SOFT_RESET_CYCLES = 4
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled_in,
	// Job control
	input  logic                    job_start,
	input  logic [LENGTH_WIDTH-1:0] job_length,
	// Memory responses
	input  logic                    resp_valid,
	input  afu_pkg::resp_kind       resp_kind,
	input  logic [DATA_WIDTH-1:0]   resp_data,
	// MMIO report
	input  logic                    done_ack,
	output logic                    job_busy,
	output logic                    return_valid,
	output logic [0:RETURN_WIDTH-1] return_done,
	output logic [STAT_WIDTH-1:0]   stat_reads,
	output logic [STAT_WIDTH-1:0]   stat_writes,
	output logic [STAT_WIDTH-1:0]   stat_errors,
	output logic [STAT_WIDTH-1:0]   stat_busy_cycles
);

	logic                    cu_done;
	logic [0:RETURN_WIDTH-1] cu_return;
	logic                    job_running;
	logic                    reset_done;
	logic                    soft_rstn;

	// Live counters and the held report
	response_stats_if live_stats ();
	response_stats_if report_stats ();

	job_engine u_job_engine (
		.clock       (clock),
		.rstn        (rstn),
		.soft_rstn   (soft_rstn),
		.job_start   (job_start),
		.job_length  (job_length),
		.resp_valid  (resp_valid),
		.resp_kind   (resp_kind),
		.resp_data   (resp_data),
		.cu_done     (cu_done),
		.cu_return   (cu_return),
		.job_running (job_running),
		.job_busy    (job_busy)
	);

	response_counter u_response_counter (
		.clock       (clock),
		.rstn        (rstn),
		.soft_rstn   (soft_rstn),
		.job_running (job_running),
		.resp_valid  (resp_valid),
		.resp_kind   (resp_kind),
		.stats       (live_stats.producer)
	);

	soft_reset_ctrl #(
		.SOFT_RESET_CYCLES (SOFT_RESET_CYCLES)
	) u_soft_reset_ctrl (
		.clock      (clock),
		.rstn       (rstn),
		.reset_done (reset_done),
		.soft_rstn  (soft_rstn)
	);

	done_control u_done_control (
		.clock        (clock),
		.rstn         (rstn),
		.soft_rstn    (soft_rstn),
		.enabled_in   (enabled_in),
		.cu_done      (cu_done),
		.cu_return    (cu_return),
		.live_stats   (live_stats.consumer),
		.done_ack     (done_ack),
		.reset_done   (reset_done),
		.return_valid (return_valid),
		.return_done  (return_done),
		.report_stats (report_stats.producer)
	);

	// Report counters out as plain ports
	assign stat_reads       = report_stats.reads;
	assign stat_writes      = report_stats.writes;
	assign stat_errors      = report_stats.errors;
	assign stat_busy_cycles = report_stats.busy_cycles;

endmodule

/* tests/afu_tb.sv */
`timescale 1ns/1ps
// Testbench of the accelerator compute unit
// Random jobs through the completion path, checked by concurrent assertions

module afu_tb import afu_pkg::*; ();

	localparam int CLK_PERIOD  = 40;
	localparam int DRIVE_DELAY = 1;
	localparam int TIMEOUT     = 100;

	logic                    clock;
	logic                    rstn;
	logic                    enabled_in;
	logic                    job_start;
	logic [LENGTH_WIDTH-1:0] job_length;
	logic                    resp_valid;
	resp_kind                kind;
	logic [DATA_WIDTH-1:0]   resp_data;
	logic                    done_ack;
	logic                    job_busy;
	logic                    return_valid;
	logic [0:RETURN_WIDTH-1] return_done;
	logic [STAT_WIDTH-1:0]   stat_reads;
	logic [STAT_WIDTH-1:0]   stat_writes;
	logic [STAT_WIDTH-1:0]   stat_errors;
	logic [STAT_WIDTH-1:0]   stat_busy_cycles;

	// Reference values of the current job
	logic [LENGTH_WIDTH-1:0] exp_count;
	logic [SUM_WIDTH-1:0]    exp_sum;
	logic [STAT_WIDTH-1:0]   exp_reads;
	logic [STAT_WIDTH-1:0]   exp_writes;
	logic [STAT_WIDTH-1:0]   exp_errors;
	logic [STAT_WIDTH-1:0]   exp_busy;

	logic [31:0] lfsr = 32'd94;
	int          mismatches = 0;
	int          failures = 0;

	afu_core u_afu_core (
		.clock            (clock),
		.rstn             (rstn),
		.enabled_in       (enabled_in),
		.job_start        (job_start),
		.job_length       (job_length),
		.resp_valid       (resp_valid),
		.resp_kind        (kind),
		.resp_data        (resp_data),
		.done_ack         (done_ack),
		.job_busy         (job_busy),
		.return_valid     (return_valid),
		.return_done      (return_done),
		.stat_reads       (stat_reads),
		.stat_writes      (stat_writes),
		.stat_errors      (stat_errors),
		.stat_busy_cycles (stat_busy_cycles)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic count_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		mismatches++;
		$display("MISMATCH %s got %h expected %h", name, got, exp);
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("%s", what);
	endtask

	task automatic end_run();
		$display("mismatches %0d failures %0d", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	endtask

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One step per bit taken
	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#(DRIVE_DELAY);
	endtask

	task automatic wait_valid(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (return_valid !== level && cycles < TIMEOUT) begin
			next_cycle();
			cycles++;
		end
		if (return_valid !== level) begin
			report_failure(what);
			end_run();
		end
	endtask

	// Writes outside a job are never tallied
	task automatic send_stray(input int n);
		logic [31:0] data;
		for (int i = 0; i < n; i++) begin
			take_bits(32, data);
			resp_valid = 1'b1;
			kind       = RESP_WRITE;
			resp_data  = data;
			next_cycle();
		end
		resp_valid = 1'b0;
	endtask

	//////////////////////////////
	// One job end to end
	//////////////////////////////

	task automatic run_job(input logic [15:0] len, input bit disturb, input bit disabled);
		logic [31:0] bits;
		logic [31:0] data;
		resp_kind    k;
		exp_count  = len;
		exp_sum    = '0;
		exp_reads  = '0;
		exp_writes = '0;
		exp_errors = '0;
		exp_busy   = '0;
		if (disturb)
			send_stray(3);
		job_start  = 1'b1;
		job_length = len;
		next_cycle();
		job_start = 1'b0;
		// Done FSM frozen across the completion
		if (disabled)
			enabled_in = 1'b0;
		for (int i = 0; i < len; i++) begin
			// Random idle gap between responses
			if (i > 0) begin
				take_bits(1, bits);
				if (bits[0]) begin
					resp_valid = 1'b0;
					next_cycle();
					exp_busy++;
				end
			end
			take_bits(2, bits);
			k = (bits[1:0] == 2'd3) ? RESP_READ : resp_kind'(bits[1:0]);
			take_bits(32, data);
			resp_valid = 1'b1;
			kind       = k;
			resp_data  = data;
			// Second start while running
			if (disturb && i == 1) begin
				job_start  = 1'b1;
				job_length = len + 16'd5;
			end
			case (k)
				RESP_WRITE : exp_writes++;
				RESP_ERROR : exp_errors++;
				default    : exp_reads++;
			endcase
			if (k != RESP_ERROR)
				exp_sum = exp_sum + SUM_WIDTH'(data);
			next_cycle();
			exp_busy++;
			job_start = 1'b0;
		end
		resp_valid = 1'b0;
		if (disturb)
			send_stray(3);
		if (disabled) begin
			repeat (16) next_cycle();
			enabled_in = 1'b1;
		end
		wait_valid(1'b1, "timeout waiting for return_valid to rise");
		// Host takes its time before the ack
		take_bits(4, bits);
		repeat (bits[3:0]) next_cycle();
		done_ack = 1'b1;
		next_cycle();
		done_ack = 1'b0;
		wait_valid(1'b0, "timeout waiting for return_valid to fall after done_ack");
	endtask

	//////////////////////////////
	// Checks
	//////////////////////////////

	a_after_reset : assert property (@(posedge clock)
		$rose(rstn) |-> (!job_busy && !return_valid))
		else report_failure("job_busy or return_valid high right after reset");

	// Report ports are zero outside the report
	a_idle_done : assert property (@(posedge clock) disable iff (!rstn)
		!return_valid |-> return_done == '0)
		else count_mismatch("return_done", $sampled(return_done), '0);

	a_idle_reads : assert property (@(posedge clock) disable iff (!rstn)
		!return_valid |-> stat_reads == '0)
		else count_mismatch("stat_reads", $sampled(stat_reads), '0);

	a_idle_writes : assert property (@(posedge clock) disable iff (!rstn)
		!return_valid |-> stat_writes == '0)
		else count_mismatch("stat_writes", $sampled(stat_writes), '0);

	a_idle_errors : assert property (@(posedge clock) disable iff (!rstn)
		!return_valid |-> stat_errors == '0)
		else count_mismatch("stat_errors", $sampled(stat_errors), '0);

	a_idle_busy : assert property (@(posedge clock) disable iff (!rstn)
		!return_valid |-> stat_busy_cycles == '0)
		else count_mismatch("stat_busy_cycles", $sampled(stat_busy_cycles), '0);

	// Values when the report appears
	a_return_done : assert property (@(posedge clock) disable iff (!rstn)
		$rose(return_valid) |-> return_done == {exp_count, exp_sum})
		else count_mismatch("return_done", $sampled(return_done), {exp_count, exp_sum});

	a_reads : assert property (@(posedge clock) disable iff (!rstn)
		$rose(return_valid) |-> stat_reads == exp_reads)
		else count_mismatch("stat_reads", $sampled(stat_reads), exp_reads);

	a_writes : assert property (@(posedge clock) disable iff (!rstn)
		$rose(return_valid) |-> stat_writes == exp_writes)
		else count_mismatch("stat_writes", $sampled(stat_writes), exp_writes);

	a_errors : assert property (@(posedge clock) disable iff (!rstn)
		$rose(return_valid) |-> stat_errors == exp_errors)
		else count_mismatch("stat_errors", $sampled(stat_errors), exp_errors);

	a_busy_cycles : assert property (@(posedge clock) disable iff (!rstn)
		$rose(return_valid) |-> stat_busy_cycles == exp_busy)
		else count_mismatch("stat_busy_cycles", $sampled(stat_busy_cycles), exp_busy);

	// Engine already cleared by the soft reset
	a_busy_cleared : assert property (@(posedge clock) disable iff (!rstn)
		$rose(return_valid) |-> !job_busy)
		else report_failure("job_busy still high when return_valid rose");

	// Registered enable puts enabled_in two cycles back
	a_enabled : assert property (@(posedge clock) disable iff (!rstn)
		$rose(return_valid) |-> $past(enabled_in, 2))
		else report_failure("return_valid rose while enabled_in was low");

	a_hold : assert property (@(posedge clock) disable iff (!rstn)
		(return_valid && !done_ack) |=> (return_valid && $stable(return_done)
			&& $stable(stat_reads) && $stable(stat_writes) && $stable(stat_errors)
			&& $stable(stat_busy_cycles)))
		else report_failure("report changed or dropped before done_ack");

	a_ack : assert property (@(posedge clock) disable iff (!rstn)
		(return_valid && done_ack && $past(enabled_in)) |=> !return_valid)
		else report_failure("return_valid stayed high after done_ack");

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		logic [31:0] bits;
		rstn       = 1'b0;
		enabled_in = 1'b1;
		job_start  = 1'b0;
		job_length = '0;
		resp_valid = 1'b0;
		kind       = RESP_READ;
		resp_data  = '0;
		done_ack   = 1'b0;
		repeat (4) @(posedge clock);
		#(DRIVE_DELAY);
		rstn = 1'b1;
		next_cycle();
		next_cycle();
		// Empty job first
		run_job(16'd0, 1'b0, 1'b0);
		for (int j = 0; j < 6; j++) begin
			take_bits(4, bits);
			run_job(16'(bits[3:0]), 1'b0, 1'b0);
		end
		run_job(16'd6, 1'b1, 1'b0);
		run_job(16'd5, 1'b0, 1'b1);
		take_bits(4, bits);
		run_job(16'(bits[3:0]), 1'b0, 1'b0);
		end_run();
	end

endmodule

/* list.f */
rtl/afu_pkg.sv
rtl/response_stats_if.sv
rtl/job_engine.sv
rtl/response_counter.sv
rtl/soft_reset_ctrl.sv
rtl/done_control.sv
rtl/afu_core.sv
tests/afu_tb.sv
